//--- hw/saturn_alu_pkg.sv
package saturn_alu_pkg;

  typedef enum logic [3:0] {
    ALU_ZERO = 4'd0,
    ALU_COPY = 4'd1,
    ALU_ADD  = 4'd2,
    ALU_SUB  = 4'd3,
    ALU_AND  = 4'd4,
    ALU_OR   = 4'd5,
    ALU_LOAD = 4'd6
  } alu_op_e;

  // A-D map onto the low two bits
  typedef enum logic [2:0] {
    REG_A   = 3'd0,
    REG_B   = 3'd1,
    REG_C   = 3'd2,
    REG_D   = 3'd3,
    REG_P   = 3'd4,
    REG_IMM = 3'd5
  } alu_reg_e;

  typedef struct packed {
    alu_op_e    op;
    alu_reg_e   dest;
    alu_reg_e   src1;
    alu_reg_e   src2;
    logic [3:0] field_start;
    logic [3:0] field_last;
    logic [3:0] imm;
    logic [6:0] pad;
  } alu_cmd_s;

  typedef struct packed {
    alu_op_e     op;
    alu_reg_e    dest;
    logic [3:0]  nib;
    logic [3:0]  value;
    logic [16:0] pad;
  } load_cmd_s;

  // op sits in bits 31:28 in both views
  typedef union packed {
    alu_cmd_s  alu;
    load_cmd_s load;
  } alu_cmd_u;

endpackage

//--- hw/saturn_alu_regs.sv
`timescale 1ns/1ns
`include "saturn_defines.svh"

module saturn_alu_regs (
  input  logic                            i_clk,
  input  logic                            i_rst,
  input  logic [`SAT_AXI_AW-1:0]          i_awaddr,
  input  logic                            i_awvalid,
  output logic                            o_awready,
  input  logic [`SAT_AXI_DW-1:0]          i_wdata,
  input  logic [`SAT_AXI_DW/8-1:0]        i_wstrb,
  input  logic                            i_wvalid,
  output logic                            o_wready,
  output logic [1:0]                      o_bresp,
  output logic                            o_bvalid,
  input  logic                            i_bready,
  input  logic [`SAT_AXI_AW-1:0]          i_araddr,
  input  logic                            i_arvalid,
  output logic                            o_arready,
  output logic [`SAT_AXI_DW-1:0]          o_rdata,
  output logic [1:0]                      o_rresp,
  output logic                            o_rvalid,
  input  logic                            i_rready,
  output logic                            o_cmd_valid,
  output saturn_alu_pkg::alu_cmd_u        o_cmd,
  input  logic                            i_busy,
  input  logic                            i_carry,
  input  logic [3:0]                      i_reg_p,
  output saturn_alu_pkg::alu_reg_e        o_rd_sel,
  input  logic [63:0]                     i_rd_data
);
  import saturn_alu_pkg::*;
  import saturn_bus_pkg::*;

  logic     wr_fire;
  logic     rd_fire;
  logic     full_strb;
  alu_reg_e sel_reg;
  logic     sel_high;
  status_s  status;

  // aw and w are taken together, only with no b pending
  assign wr_fire   = i_awvalid && i_wvalid && !o_bvalid;
  assign rd_fire   = i_arvalid && !o_rvalid;
  assign o_awready = i_wvalid && !o_bvalid;
  assign o_wready  = i_awvalid && !o_bvalid;
  assign o_arready = !o_rvalid;
  assign full_strb = &i_wstrb;

  assign o_rd_sel = sel_reg;
  assign status   = '{pad: '0, p: i_reg_p, carry: i_carry, busy: i_busy};

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_bvalid    <= 1'b0;
      o_bresp     <= RESP_OKAY;
      o_cmd_valid <= 1'b0;
      sel_reg     <= REG_A;
      sel_high    <= 1'b0;
    end else begin
      o_cmd_valid <= 1'b0;
      if (o_bvalid && i_bready) begin
        o_bvalid <= 1'b0;
      end
      if (wr_fire) begin
        o_bvalid <= 1'b1;
        o_bresp  <= RESP_SLVERR;
        if (full_strb) begin
          case (i_awaddr)
            `SAT_OFF_CMD: begin
              // dropped while the alu still runs
              if (!i_busy) begin
                o_cmd_valid <= 1'b1;
                o_bresp     <= RESP_OKAY;
              end
            end
            `SAT_OFF_SEL: begin
              // bits 2:0 register id, bit 3 high half
              sel_reg  <= alu_reg_e'(i_wdata[2:0]);
              sel_high <= i_wdata[3];
              o_bresp  <= RESP_OKAY;
            end
            default: ;
          endcase
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (wr_fire && i_awaddr == `SAT_OFF_CMD) begin
      o_cmd <= i_wdata;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rvalid <= 1'b0;
      o_rresp  <= RESP_OKAY;
    end else begin
      if (o_rvalid && i_rready) begin
        o_rvalid <= 1'b0;
      end
      if (rd_fire) begin
        o_rvalid <= 1'b1;
        if (i_araddr == `SAT_OFF_STATUS || i_araddr == `SAT_OFF_DATA) begin
          o_rresp <= RESP_OKAY;
        end else begin
          o_rresp <= RESP_SLVERR;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (rd_fire) begin
      case (i_araddr)
        `SAT_OFF_STATUS: o_rdata <= status;
        `SAT_OFF_DATA:   o_rdata <= sel_high ? i_rd_data[63:32] : i_rd_data[31:0];
        default:         o_rdata <= '0;
      endcase
    end
  end

endmodule

//--- hw/saturn_alu_top.sv
`timescale 1ns/1ns
`include "saturn_defines.svh"

module saturn_alu_top (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  logic [`SAT_AXI_AW-1:0]   i_awaddr,
  input  logic                     i_awvalid,
  output logic                     o_awready,
  input  logic [`SAT_AXI_DW-1:0]   i_wdata,
  input  logic [`SAT_AXI_DW/8-1:0] i_wstrb,
  input  logic                     i_wvalid,
  output logic                     o_wready,
  output logic [1:0]               o_bresp,
  output logic                     o_bvalid,
  input  logic                     i_bready,
  input  logic [`SAT_AXI_AW-1:0]   i_araddr,
  input  logic                     i_arvalid,
  output logic                     o_arready,
  output logic [`SAT_AXI_DW-1:0]   o_rdata,
  output logic [1:0]               o_rresp,
  output logic                     o_rvalid,
  input  logic                     i_rready
);
  import saturn_alu_pkg::*;

  logic        cmd_valid;
  alu_cmd_u    cmd;
  logic        busy;
  logic        carry;
  logic        carry_wr;
  logic        carry_en;
  logic [3:0]  reg_p;
  alu_reg_e    wide_sel;
  logic [63:0] wide_data;
  alu_reg_e    rd1_sel;
  alu_reg_e    rd2_sel;
  logic [3:0]  rd_nib;
  logic [3:0]  rd1;
  logic [3:0]  rd2;
  logic        wr_en;
  alu_reg_e    wr_sel;
  logic [3:0]  wr_nib;
  logic [3:0]  wr_data;

  saturn_alu_regs u_regs (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_awaddr    (i_awaddr),
    .i_awvalid   (i_awvalid),
    .o_awready   (o_awready),
    .i_wdata     (i_wdata),
    .i_wstrb     (i_wstrb),
    .i_wvalid    (i_wvalid),
    .o_wready    (o_wready),
    .o_bresp     (o_bresp),
    .o_bvalid    (o_bvalid),
    .i_bready    (i_bready),
    .i_araddr    (i_araddr),
    .i_arvalid   (i_arvalid),
    .o_arready   (o_arready),
    .o_rdata     (o_rdata),
    .o_rresp     (o_rresp),
    .o_rvalid    (o_rvalid),
    .i_rready    (i_rready),
    .o_cmd_valid (cmd_valid),
    .o_cmd       (cmd),
    .i_busy      (busy),
    .i_carry     (carry),
    .i_reg_p     (reg_p),
    .o_rd_sel    (wide_sel),
    .i_rd_data   (wide_data)
  );

  saturn_nibble_alu u_alu (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_cmd_valid (cmd_valid),
    .i_cmd       (cmd),
    .o_busy      (busy),
    .o_rd1_sel   (rd1_sel),
    .o_rd2_sel   (rd2_sel),
    .o_rd_nib    (rd_nib),
    .i_rd1       (rd1),
    .i_rd2       (rd2),
    .o_wr_en     (wr_en),
    .o_wr_sel    (wr_sel),
    .o_wr_nib    (wr_nib),
    .o_wr_data   (wr_data),
    .o_carry_en  (carry_en),
    .o_carry     (carry_wr),
    .i_carry     (carry)
  );

  saturn_reg_file u_reg_file (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_rd1_sel   (rd1_sel),
    .i_rd2_sel   (rd2_sel),
    .i_rd_nib    (rd_nib),
    .o_rd1       (rd1),
    .o_rd2       (rd2),
    .i_wr_en     (wr_en),
    .i_wr_sel    (wr_sel),
    .i_wr_nib    (wr_nib),
    .i_wr_data   (wr_data),
    .i_carry_en  (carry_en),
    .i_carry     (carry_wr),
    .o_carry     (carry),
    .o_p         (reg_p),
    .i_wide_sel  (wide_sel),
    .o_wide_data (wide_data)
  );

endmodule

//--- hw/saturn_bus_pkg.sv
package saturn_bus_pkg;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  // busy in bit 0, carry in bit 1, P in bits 5:2
  typedef struct packed {
    logic [25:0] pad;
    logic [3:0]  p;
    logic        carry;
    logic        busy;
  } status_s;

endpackage

//--- hw/saturn_nibble_alu.sv
`timescale 1ns/1ns

module saturn_nibble_alu (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  logic                     i_cmd_valid,
  input  saturn_alu_pkg::alu_cmd_u i_cmd,
  output logic                     o_busy,
  output saturn_alu_pkg::alu_reg_e o_rd1_sel,
  output saturn_alu_pkg::alu_reg_e o_rd2_sel,
  output logic [3:0]               o_rd_nib,
  input  logic [3:0]               i_rd1,
  input  logic [3:0]               i_rd2,
  output logic                     o_wr_en,
  output saturn_alu_pkg::alu_reg_e o_wr_sel,
  output logic [3:0]               o_wr_nib,
  output logic [3:0]               o_wr_data,
  output logic                     o_carry_en,
  output logic                     o_carry,
  input  logic                     i_carry
);
  import saturn_alu_pkg::*;

  localparam logic [1:0] PH_PREP = 2'd0;
  localparam logic [1:0] PH_CALC = 2'd1;
  localparam logic [1:0] PH_SAVE = 2'd2;

  logic [1:0] phase;
  alu_op_e    op;
  alu_reg_e   dest;
  alu_reg_e   src1;
  alu_reg_e   src2;
  logic [3:0] imm;
  logic [3:0] cur_nib;
  logic [3:0] last_nib;
  logic       run_carry;
  logic [3:0] p_src1;
  logic [3:0] p_src2;
  logic [3:0] c_res;
  logic       c_carry;
  logic       save_now;
  logic       is_last;
  logic       is_arith;

  assign save_now = o_busy && phase == PH_SAVE;
  assign is_last  = cur_nib == last_nib;
  assign is_arith = op == ALU_ADD || op == ALU_SUB;

  assign o_rd1_sel = src1;
  assign o_rd2_sel = src2;
  assign o_rd_nib  = cur_nib;

  // P is a one-nibble register living at nibble 0
  assign o_wr_en   = save_now && (dest != REG_P || cur_nib == 4'd0);
  assign o_wr_sel  = dest;
  assign o_wr_nib  = cur_nib;
  assign o_wr_data = c_res;

  // carry rewritten at the end of every command, kept unless arithmetic
  assign o_carry_en = save_now && is_last;
  assign o_carry    = is_arith ? c_carry : i_carry;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_busy    <= 1'b0;
      phase     <= PH_PREP;
      cur_nib   <= '0;
      last_nib  <= '0;
      run_carry <= 1'b0;
    end else if (i_cmd_valid && !o_busy) begin
      o_busy    <= 1'b1;
      phase     <= PH_PREP;
      run_carry <= 1'b0;
      if (i_cmd.alu.op == ALU_LOAD) begin
        cur_nib  <= i_cmd.load.nib;
        last_nib <= i_cmd.load.nib;
      end else begin
        cur_nib <= i_cmd.alu.field_start;
        // a reversed field collapses to its start nibble
        if (i_cmd.alu.field_last < i_cmd.alu.field_start) begin
          last_nib <= i_cmd.alu.field_start;
        end else begin
          last_nib <= i_cmd.alu.field_last;
        end
      end
    end else if (o_busy) begin
      case (phase)
        PH_PREP: phase <= PH_CALC;
        PH_CALC: phase <= PH_SAVE;
        default: begin
          phase     <= PH_PREP;
          run_carry <= c_carry;
          if (is_last) begin
            o_busy <= 1'b0;
          end else begin
            cur_nib <= cur_nib + 4'd1;
          end
        end
      endcase
    end
  end

  // command fields, load is a copy of its value nibble
  always_ff @(posedge i_clk) begin
    if (i_cmd_valid && !o_busy) begin
      op   <= i_cmd.alu.op;
      dest <= i_cmd.alu.dest;
      if (i_cmd.alu.op == ALU_LOAD) begin
        src1 <= REG_IMM;
        src2 <= REG_IMM;
        imm  <= i_cmd.load.value;
      end else begin
        src1 <= i_cmd.alu.src1;
        src2 <= i_cmd.alu.src2;
        imm  <= i_cmd.alu.imm;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_busy && phase == PH_PREP) begin
      p_src1 <= (src1 == REG_IMM) ? imm : i_rd1;
      p_src2 <= (src2 == REG_IMM) ? imm : i_rd2;
    end
    if (o_busy && phase == PH_CALC) begin
      c_carry <= run_carry;
      case (op)
        ALU_COPY, ALU_LOAD: c_res <= p_src1;
        ALU_ADD: {c_carry, c_res} <= {1'b0, p_src1} + {1'b0, p_src2} + {4'b0, run_carry};
        // bit 4 is the borrow out
        ALU_SUB: {c_carry, c_res} <= {1'b0, p_src1} - {1'b0, p_src2} - {4'b0, run_carry};
        ALU_AND: c_res <= p_src1 & p_src2;
        ALU_OR:  c_res <= p_src1 | p_src2;
        default: c_res <= 4'h0;
      endcase
    end
  end

endmodule

//--- hw/saturn_reg_file.sv
`timescale 1ns/1ns
`include "saturn_defines.svh"

module saturn_reg_file (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  saturn_alu_pkg::alu_reg_e i_rd1_sel,
  input  saturn_alu_pkg::alu_reg_e i_rd2_sel,
  input  logic [3:0]               i_rd_nib,
  output logic [3:0]               o_rd1,
  output logic [3:0]               o_rd2,
  input  logic                     i_wr_en,
  input  saturn_alu_pkg::alu_reg_e i_wr_sel,
  input  logic [3:0]               i_wr_nib,
  input  logic [3:0]               i_wr_data,
  input  logic                     i_carry_en,
  input  logic                     i_carry,
  output logic                     o_carry,
  output logic [3:0]               o_p,
  input  saturn_alu_pkg::alu_reg_e i_wide_sel,
  output logic [63:0]              o_wide_data
);
  import saturn_alu_pkg::*;

  // A-D, indexed by the low bits of the register id
  logic [3:0] regs [4][`SAT_NIBBLES];
  logic [3:0] p;
  logic       carry;

  function automatic logic [3:0] read_nib(alu_reg_e sel, logic [3:0] nib);
    logic [3:0] val;
    val = 4'h0;
    if (sel == REG_P) begin
      val = (nib == 4'd0) ? p : 4'h0;
    end else if (sel != REG_IMM) begin
      val = regs[sel[1:0]][nib];
    end
    return val;
  endfunction

  assign o_rd1   = read_nib(i_rd1_sel, i_rd_nib);
  assign o_rd2   = read_nib(i_rd2_sel, i_rd_nib);
  assign o_p     = p;
  assign o_carry = carry;

  always_comb begin
    o_wide_data = '0;
    if (i_wide_sel == REG_P) begin
      o_wide_data = {60'b0, p};
    end else if (i_wide_sel != REG_IMM) begin
      for (int n = 0; n < `SAT_NIBBLES; n++) begin
        o_wide_data[4*n +: 4] = regs[i_wide_sel[1:0]][n];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int r = 0; r < 4; r++) begin
        for (int n = 0; n < `SAT_NIBBLES; n++) begin
          regs[r][n] <= 4'h0;
        end
      end
      p     <= 4'h0;
      carry <= 1'b0;
    end else begin
      if (i_wr_en && i_wr_sel == REG_P) begin
        p <= i_wr_data;
      end else if (i_wr_en && i_wr_sel != REG_IMM) begin
        regs[i_wr_sel[1:0]][i_wr_nib] <= i_wr_data;
      end
      if (i_carry_en) begin
        carry <= i_carry;
      end
    end
  end

endmodule

//--- include/saturn_defines.svh
`ifndef SATURN_DEFINES_SVH
`define SATURN_DEFINES_SVH

// nibbles per working register
`define SAT_NIBBLES 16

// axi4-lite port widths
`define SAT_AXI_AW 4
`define SAT_AXI_DW 32

// register map, byte offsets
`define SAT_OFF_CMD    4'h0
`define SAT_OFF_STATUS 4'h4
`define SAT_OFF_SEL    4'h8
`define SAT_OFF_DATA   4'hC

`endif

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module saturn_alu_tb -f src.f -o saturn_alu_tb
./obj_dir/saturn_alu_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation failed" sim.log; then
  exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
  exit 1
fi

//--- sim/saturn_alu_assert.sv
`timescale 1ns/1ns

module saturn_alu_assert (
  input logic i_clk,
  input logic i_rst,
  input logic i_bvalid,
  input logic i_bready,
  input logic i_rvalid,
  input logic i_rready,
  input logic i_cmd_valid,
  input logic i_busy
);

  // responses hold until the master takes them
  bvalid_held: assert property (@(posedge i_clk) disable iff (i_rst)
    i_bvalid && !i_bready |=> i_bvalid)
    else $error("bvalid dropped before bready");

  rvalid_held: assert property (@(posedge i_clk) disable iff (i_rst)
    i_rvalid && !i_rready |=> i_rvalid)
    else $error("rvalid dropped before rready");

  cmd_one_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
    i_cmd_valid |=> !i_cmd_valid)
    else $error("cmd_valid held longer than one cycle");

  // a command only goes out to an idle alu
  cmd_when_idle: assert property (@(posedge i_clk) disable iff (i_rst)
    i_cmd_valid |-> !i_busy)
    else $error("cmd_valid raised while busy");

  busy_after_reset: assert property (@(posedge i_clk)
    i_rst |=> !i_busy)
    else $error("busy high after reset");

endmodule

bind saturn_alu_regs saturn_alu_assert u_assert (
  .i_clk       (i_clk),
  .i_rst       (i_rst),
  .i_bvalid    (o_bvalid),
  .i_bready    (i_bready),
  .i_rvalid    (o_rvalid),
  .i_rready    (i_rready),
  .i_cmd_valid (o_cmd_valid),
  .i_busy      (i_busy)
);

//--- sim/saturn_alu_tb.sv
`timescale 1ns/1ns
`include "saturn_defines.svh"

module saturn_alu_tb;
  import saturn_alu_pkg::*;

  localparam int          TIMEOUT   = 64;
  localparam int          MAX_POLLS = 100;
  localparam logic [31:0] OKAY      = 32'h0;
  localparam logic [31:0] SLVERR    = 32'h2;

  logic                     i_clk;
  logic                     i_rst;
  logic [`SAT_AXI_AW-1:0]   i_awaddr;
  logic                     i_awvalid;
  logic                     o_awready;
  logic [`SAT_AXI_DW-1:0]   i_wdata;
  logic [`SAT_AXI_DW/8-1:0] i_wstrb;
  logic                     i_wvalid;
  logic                     o_wready;
  logic [1:0]               o_bresp;
  logic                     o_bvalid;
  logic                     i_bready;
  logic [`SAT_AXI_AW-1:0]   i_araddr;
  logic                     i_arvalid;
  logic                     o_arready;
  logic [`SAT_AXI_DW-1:0]   o_rdata;
  logic [1:0]               o_rresp;
  logic                     o_rvalid;
  logic                     i_rready;

  // reference model state
  logic [63:0] m_reg [4];
  logic [3:0]  m_p;
  logic        m_carry;

  int          errors;
  int          timeouts;
  logic [1:0]  resp;
  logic [31:0] rdata;
  logic [3:0]  op;
  logic [2:0]  dest;
  logic [2:0]  src1;
  logic [2:0]  src2;
  int          start;
  int          last;
  logic [3:0]  imm;

  saturn_alu_top DUT (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_awaddr  (i_awaddr),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_wdata   (i_wdata),
    .i_wstrb   (i_wstrb),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .o_bresp   (o_bresp),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .i_araddr  (i_araddr),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .o_rdata   (o_rdata),
    .o_rresp   (o_rresp),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready)
  );

  always #50 i_clk = ~i_clk;

  task automatic report_timeout(input string what);
    $display("timeout waiting for %s", what);
    timeouts++;
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  // called on a rising edge, returns on the edge of the b transfer
  task automatic write_word(input logic [3:0] addr, input logic [31:0] data,
                            output logic [1:0] bresp);
    int cycles;
    i_awaddr  <= addr;
    i_awvalid <= 1'b1;
    i_wdata   <= data;
    i_wvalid  <= 1'b1;
    cycles = 0;
    do begin
      @(posedge i_clk);
      cycles++;
    end while (!(o_awready && o_wready) && cycles < TIMEOUT);
    if (!(o_awready && o_wready)) report_timeout("write address and data");
    i_awvalid <= 1'b0;
    i_wvalid  <= 1'b0;
    i_bready  <= 1'b1;
    cycles = 0;
    do begin
      @(posedge i_clk);
      cycles++;
    end while (!o_bvalid && cycles < TIMEOUT);
    if (!o_bvalid) report_timeout("write response");
    bresp = o_bresp;
    i_bready <= 1'b0;
  endtask

  task automatic read_word(input logic [3:0] addr, output logic [31:0] data,
                           output logic [1:0] rresp);
    int cycles;
    i_araddr  <= addr;
    i_arvalid <= 1'b1;
    cycles = 0;
    do begin
      @(posedge i_clk);
      cycles++;
    end while (!o_arready && cycles < TIMEOUT);
    if (!o_arready) report_timeout("read address");
    i_arvalid <= 1'b0;
    i_rready  <= 1'b1;
    cycles = 0;
    do begin
      @(posedge i_clk);
      cycles++;
    end while (!o_rvalid && cycles < TIMEOUT);
    if (!o_rvalid) report_timeout("read data");
    data  = o_rdata;
    rresp = o_rresp;
    i_rready <= 1'b0;
  endtask

  task automatic wait_idle();
    int          polls;
    logic [31:0] status;
    logic [1:0]  sresp;
    polls = 0;
    do begin
      read_word(`SAT_OFF_STATUS, status, sresp);
      polls++;
    end while (status[0] && polls < MAX_POLLS);
    if (status[0]) report_timeout("busy to clear");
  endtask

  task automatic run_cmd(input string name, input logic [31:0] word);
    logic [1:0] bresp;
    write_word(`SAT_OFF_CMD, word, bresp);
    check($sformatf("%s cmd resp", name), OKAY, {30'b0, bresp});
    wait_idle();
  endtask

  // both halves of A-D and P, then the status word
  task automatic compare_all(input string name);
    logic [63:0] expected;
    logic [31:0] data;
    logic [1:0]  bresp;
    for (int r = 0; r < 5; r++) begin
      expected = (r < 4) ? m_reg[r] : {60'b0, m_p};
      for (int h = 0; h < 2; h++) begin
        write_word(`SAT_OFF_SEL, 32'(h * 8 + r), bresp);
        read_word(`SAT_OFF_DATA, data, bresp);
        check($sformatf("%s reg %0d half %0d", name, r, h),
              (h == 1) ? expected[63:32] : expected[31:0], data);
      end
    end
    read_word(`SAT_OFF_STATUS, data, bresp);
    check($sformatf("%s status", name), {26'b0, m_p, m_carry, 1'b0}, data);
  endtask

  task automatic pick_fields();
    dest  = 3'($urandom_range(4, 0));
    src1  = 3'($urandom_range(5, 0));
    src2  = 3'($urandom_range(5, 0));
    start = $urandom_range(15, 0);
    last  = $urandom_range(15, 0);
    imm   = 4'($urandom_range(15, 0));
  endtask

  function automatic logic [31:0] cmd_word();
    return {op, dest, src1, src2, 4'(start), 4'(last), imm, 7'b0};
  endfunction

  // P reads as a single nibble at index 0
  function automatic logic [3:0] source_nibble(input logic [2:0] id, input int n);
    if (id == REG_IMM) return imm;
    if (id == REG_P) return (n == 0) ? m_p : 4'h0;
    return m_reg[id[1:0]][4*n +: 4];
  endfunction

  function automatic void apply_alu();
    int         final_n;
    int         sum;
    logic [3:0] a;
    logic [3:0] b;
    logic [3:0] r;
    logic       c;
    final_n = (last < start) ? start : last;
    c = 1'b0;
    for (int n = start; n <= final_n; n++) begin
      a = source_nibble(src1, n);
      b = source_nibble(src2, n);
      case (op)
        ALU_COPY: r = a;
        // digit sums in plain integers, carry and borrow from the range
        ALU_ADD: begin
          sum = int'(a) + int'(b) + int'(c);
          r   = 4'(sum & 15);
          c   = sum > 15;
        end
        ALU_SUB: begin
          sum = int'(a) - int'(b) - int'(c);
          r   = 4'(sum & 15);
          c   = sum < 0;
        end
        ALU_AND: r = a & b;
        ALU_OR:  r = a | b;
        default: r = 4'h0;
      endcase
      if (dest < REG_P) begin
        m_reg[dest[1:0]][4*n +: 4] = r;
      end else if (dest == REG_P && n == 0) begin
        m_p = r;
      end
    end
    if (op == ALU_ADD || op == ALU_SUB) m_carry = c;
  endfunction

  function automatic void apply_load();
    if (dest < REG_P) begin
      m_reg[dest[1:0]][4*start +: 4] = imm;
    end else if (dest == REG_P && start == 0) begin
      m_p = imm;
    end
  endfunction

  task automatic run_alu(input string name);
    run_cmd(name, cmd_word());
    apply_alu();
    compare_all(name);
  endtask

  initial begin
    i_clk     = 1'b0;
    i_rst     = 1'b1;
    i_awaddr  = '0;
    i_awvalid = 1'b0;
    i_wdata   = '0;
    i_wstrb   = '1;
    i_wvalid  = 1'b0;
    i_bready  = 1'b0;
    i_araddr  = '0;
    i_arvalid = 1'b0;
    i_rready  = 1'b0;
    errors    = 0;
    timeouts  = 0;
    void'($urandom(37993));
    for (int r = 0; r < 4; r++) m_reg[r] = 64'h0;
    m_p     = 4'h0;
    m_carry = 1'b0;
    repeat (8) @(posedge i_clk);
    i_rst <= 1'b0;

    compare_all("reset");

    repeat (24) begin
      pick_fields();
      run_cmd("load", {ALU_LOAD, dest, 4'(start), imm, 17'b0});
      apply_load();
    end
    compare_all("load");

    repeat (25) begin
      pick_fields();
      case ($urandom_range(3, 0))
        0: op = ALU_ZERO;
        1: op = ALU_COPY;
        2: op = ALU_AND;
        default: op = ALU_OR;
      endcase
      run_alu($sformatf("logic op %0d", op));
    end

    repeat (25) begin
      pick_fields();
      op = ($urandom_range(1, 0) == 1) ? ALU_ADD : ALU_SUB;
      run_alu($sformatf("arith op %0d", op));
    end

    // long add keeps the alu busy for 48 cycles
    op    = ALU_ADD;
    dest  = REG_A;
    src1  = REG_A;
    src2  = REG_B;
    start = 0;
    last  = 15;
    write_word(`SAT_OFF_CMD, cmd_word(), resp);
    check("long cmd resp", OKAY, {30'b0, resp});
    apply_alu();
    read_word(`SAT_OFF_STATUS, rdata, resp);
    check("busy after cmd", 32'h1, {31'b0, rdata[0]});
    // a copy that would change nibble 0 of B if it ran
    op   = ALU_COPY;
    dest = REG_B;
    src1 = REG_IMM;
    imm  = ~m_reg[1][3:0];
    write_word(`SAT_OFF_CMD, cmd_word(), resp);
    check("cmd while busy", SLVERR, {30'b0, resp});
    wait_idle();
    compare_all("refused");
    run_alu("after idle");

    read_word(4'h2, rdata, resp);
    check("unmapped read", SLVERR, {30'b0, resp});
    read_word(`SAT_OFF_CMD, rdata, resp);
    check("cmd read", SLVERR, {30'b0, resp});

    $display("checks done, errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+include
hw/saturn_alu_pkg.sv
hw/saturn_bus_pkg.sv
hw/saturn_reg_file.sv
hw/saturn_nibble_alu.sv
hw/saturn_alu_regs.sv
hw/saturn_alu_top.sv
sim/saturn_alu_assert.sv
sim/saturn_alu_tb.sv
